// File: verilog/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// geometry of the main memory
`define MEM_DATA_W 32                           // bits per word
`define MEM_STRB_W (`MEM_DATA_W / 8)            // byte lanes per word
`define MEM_WORDS 512                           // total words over all banks
`define MEM_BANKS 4                             // interleaved banks, power of two
`define MEM_BANK_W 2                            // log2 of bank count
`define MEM_ROW_W 7                             // log2 of words per bank

// AXI4-Lite side
`define MEM_ADDR_W 32                           // byte address width
`define MEM_WINDOW (`MEM_WORDS * `MEM_STRB_W)   // decoded window in bytes, 2 KB

`endif

// File: verilog/memPkg.sv
`include "mem_params.svh"

package memPkg;

    // one bank access, broadcast to all banks and qualified by a per-bank enable
    typedef struct packed {
        logic [`MEM_ROW_W-1:0]  row;    // word row inside the bank
        logic                   write;  // 1 = write, 0 = read
        logic [`MEM_DATA_W-1:0] wdata;  // write payload
        logic [`MEM_STRB_W-1:0] strb;   // byte lanes to update
    } bankReq_t;

    // AXI response codes used by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axiResp_t;

    // pending read, front end -> read merge
    typedef struct packed {
        logic                   valid;  // bank read issued this cycle
        logic [`MEM_BANK_W-1:0] bank;   // which bank answers
        logic                   err;    // out of window, answer zero/SLVERR
    } readTag_t;

endpackage

// File: verilog/memBank.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module memBank
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   en,     // this bank is addressed this cycle
    input  bankReq_t               req,    // shared request from the front end
    output logic [`MEM_DATA_W-1:0] rdata   // registered read word
);

    localparam int Rows = `MEM_WORDS / `MEM_BANKS; // 128 rows per bank

    logic [`MEM_DATA_W-1:0] mem [Rows];  // contents undefined after power-up

    // single port: a cycle is either a write or a read, never both
    always_ff @(posedge clk) begin
        if (en) begin
            if (req.write) begin
                for (int b = 0; b < `MEM_STRB_W; b++) begin
                    if (req.strb[b]) begin
                        mem[req.row][8*b +: 8] <= req.wdata[8*b +: 8]; // strobed byte only
                    end
                end
            end else begin
                rdata <= mem[req.row];   // read port, holds until next read
            end
        end
    end

endmodule

// File: verilog/axiLiteFrontEnd.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module axiLiteFrontEnd
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // write address channel
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`MEM_ADDR_W-1:0] awaddr,
    // write data channel
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`MEM_DATA_W-1:0] wdata,
    input  logic [`MEM_STRB_W-1:0] wstrb,
    // write response channel
    output logic                   bvalid,
    input  logic                   bready,
    output axiResp_t               bresp,
    // read address channel
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`MEM_ADDR_W-1:0] araddr,
    // bank side
    output logic [`MEM_BANKS-1:0]  bankEn,    // one-hot or zero
    output bankReq_t               req,
    output readTag_t               readTag,   // valid in the bank read issue cycle
    input  logic                   readIdle   // no read in flight in readMerge
);

    localparam int ByteOffW = $clog2(`MEM_STRB_W); // byte offset bits in an address

    logic [`MEM_ADDR_W-1:0] awAddrQ;   // captured write address
    logic [`MEM_DATA_W-1:0] wDataQ;    // captured write data
    logic [`MEM_STRB_W-1:0] wStrbQ;    // captured byte strobe
    logic [`MEM_ADDR_W-1:0] arAddrQ;   // captured read address
    logic                   awHeld;    // AW taken, waiting for B
    logic                   wHeld;     // W taken, waiting for B
    logic                   arHeld;    // AR taken, bank read not yet issued
    logic                   wrIssued;  // bank write went out, B comes next
    logic                   awFire;
    logic                   wFire;
    logic                   arFire;
    logic                   bFire;
    logic                   awErr;
    logic                   arErr;
    logic                   wrGo;      // issue the bank write now
    logic                   rdGo;      // issue the bank read now

    // word index = addr / 4; its low bits pick the bank, the rest the row
    function automatic logic [`MEM_BANK_W-1:0] bankOf(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[ByteOffW +: `MEM_BANK_W];
    endfunction

    function automatic logic [`MEM_ROW_W-1:0] rowOf(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[ByteOffW + `MEM_BANK_W +: `MEM_ROW_W];
    endfunction

    function automatic logic outOfRange(input logic [`MEM_ADDR_W-1:0] addr);
        return addr >= `MEM_ADDR_W'(`MEM_WINDOW);
    endfunction

    assign awready = !awHeld;              // one write at a time, reopens after B
    assign wready  = !wHeld;
    assign arready = readIdle && !arHeld;  // single read outstanding

    assign awFire = awvalid && awready;
    assign wFire  = wvalid && wready;
    assign arFire = arvalid && arready;
    assign bFire  = bvalid && bready;

    assign awErr = outOfRange(awAddrQ);
    assign arErr = outOfRange(arAddrQ);

    // write wins a shared cycle; wrGo lasts one cycle so a read waits at most one
    assign wrGo = awHeld && wHeld && !wrIssued;
    assign rdGo = arHeld && !wrGo;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            awHeld   <= 1'b0;
            wHeld    <= 1'b0;
            arHeld   <= 1'b0;
            wrIssued <= 1'b0;
            bvalid   <= 1'b0;
            bankEn   <= '0;
            readTag  <= '0;
        end else begin
            if (awFire) awHeld <= 1'b1;
            if (wFire) wHeld <= 1'b1;

            if (rdGo) begin
                arHeld <= 1'b0;            // handed over to the banks
            end else if (arFire) begin
                arHeld <= 1'b1;
            end

            if (wrGo) wrIssued <= 1'b1;
            if (wrIssued && !bvalid) bvalid <= 1'b1;  // one cycle after the issue

            if (bFire) begin
                awHeld   <= 1'b0;          // frees AW and W for the next write
                wHeld    <= 1'b0;
                wrIssued <= 1'b0;
                bvalid   <= 1'b0;
            end

            bankEn        <= '0;           // enables are single-cycle pulses
            readTag.valid <= 1'b0;
            if (wrGo) begin
                if (!awErr) bankEn[bankOf(awAddrQ)] <= 1'b1;  // bad address writes nothing
            end else if (rdGo) begin
                readTag <= '{valid: 1'b1, bank: bankOf(arAddrQ), err: arErr};
                if (!arErr) bankEn[bankOf(arAddrQ)] <= 1'b1;
            end
        end
    end

    // holding registers and bank payload
    always_ff @(posedge clk) begin
        if (awFire) awAddrQ <= awaddr;
        if (wFire) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
        if (arFire) arAddrQ <= araddr;

        if (wrGo) begin
            req.row   <= rowOf(awAddrQ);
            req.write <= 1'b1;
            req.wdata <= wDataQ;
            req.strb  <= wStrbQ;
            bresp     <= awErr ? SLVERR : OKAY;  // stable until the next write
        end else if (rdGo) begin
            req.row   <= rowOf(arAddrQ);
            req.write <= 1'b0;
            req.strb  <= '0;
        end
    end

endmodule

// File: verilog/readMerge.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module readMerge
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  readTag_t               readTag,               // from the front end
    input  logic [`MEM_DATA_W-1:0] bankData [`MEM_BANKS], // registered bank words
    output logic                   readIdle,              // nothing in flight
    // read data channel
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`MEM_DATA_W-1:0] rdata,
    output axiResp_t               rresp
);

    readTag_t               tagQ;        // tag delayed to line up with the bank word
    logic                   holdValid;   // response parked under back-pressure
    logic [`MEM_DATA_W-1:0] holdData;
    axiResp_t               holdResp;
    logic [`MEM_DATA_W-1:0] mergedData;  // word picked from the banks this cycle
    axiResp_t               mergedResp;

    assign mergedData = tagQ.err ? '0 : bankData[tagQ.bank];  // zero on bad address
    assign mergedResp = tagQ.err ? SLVERR : OKAY;

    // first cycle straight from the bank, later cycles from the hold register
    assign rvalid = tagQ.valid || holdValid;
    assign rdata  = holdValid ? holdData : mergedData;
    assign rresp  = holdValid ? holdResp : mergedResp;

    assign readIdle = !(readTag.valid || tagQ.valid || holdValid);

    always_ff @(posedge clk) begin
        if (reset) begin
            tagQ      <= '0;
            holdValid <= 1'b0;
        end else begin
            tagQ <= readTag;                     // one-cycle delay
            if (tagQ.valid && !rready) begin
                holdValid <= 1'b1;               // not taken, park it
            end else if (holdValid && rready) begin
                holdValid <= 1'b0;               // R handshake done
            end
        end
    end

    // load on the first response cycle, bank output is ignored afterwards
    always_ff @(posedge clk) begin
        if (tagQ.valid) begin
            holdData <= mergedData;
            holdResp <= mergedResp;
        end
    end

endmodule

// File: verilog/memSubsystem.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module memSubsystem
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`MEM_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`MEM_DATA_W-1:0] wdata,
    input  logic [`MEM_STRB_W-1:0] wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output axiResp_t               bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`MEM_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`MEM_DATA_W-1:0] rdata,
    output axiResp_t               rresp
);

    logic [`MEM_BANKS-1:0]  bankEn;                // one enable per bank
    bankReq_t               bankReq;               // shared by all banks
    readTag_t               readTag;
    logic                   readIdle;
    logic [`MEM_DATA_W-1:0] bankData [`MEM_BANKS]; // read word of each bank

    axiLiteFrontEnd i_frontEnd (
        .clk, .reset,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .bankEn, .req(bankReq), .readTag, .readIdle
    );

    // word-interleaved banks, bank = word index modulo 4
    for (genvar g = 0; g < `MEM_BANKS; g++) begin : gBank
        memBank i_bank (
            .clk,
            .en(bankEn[g]),
            .req(bankReq),
            .rdata(bankData[g])
        );
    end

    readMerge i_readMerge (
        .clk, .reset,
        .readTag, .bankData, .readIdle,
        .rvalid, .rready, .rdata, .rresp
    );

endmodule

// File: test/memSubsystem_sva.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module memSubsystemSva
    import memPkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   awvalid,
    input logic                   awready,
    input logic [`MEM_ADDR_W-1:0] awaddr,
    input logic                   wvalid,
    input logic                   wready,
    input logic [`MEM_DATA_W-1:0] wdata,
    input logic [`MEM_STRB_W-1:0] wstrb,
    input logic                   bvalid,
    input logic                   bready,
    input axiResp_t               bresp,
    input logic                   arvalid,
    input logic                   arready,
    input logic [`MEM_ADDR_W-1:0] araddr,
    input logic                   rvalid,
    input logic                   rready,
    input logic [`MEM_DATA_W-1:0] rdata,
    input axiResp_t               rresp
);

    int failCount = 0;  // summed into the testbench verdict

    // responses held with a stable payload until taken
    bHold: assert property (@(posedge clk) disable iff (reset)
            bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            failCount++;
            $error("BVALID dropped or BRESP changed before BREADY");
        end

    rHold: assert property (@(posedge clk) disable iff (reset)
            rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            failCount++;
            $error("RVALID dropped or R payload changed before RREADY");
        end

    // master side, checks the stimulus too
    awHold: assert property (@(posedge clk) disable iff (reset)
            awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            failCount++;
            $error("AWVALID dropped or AWADDR changed before AWREADY");
        end

    wHold: assert property (@(posedge clk) disable iff (reset)
            wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            failCount++;
            $error("WVALID dropped or W payload changed before WREADY");
        end

    arHold: assert property (@(posedge clk) disable iff (reset)
            arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            failCount++;
            $error("ARVALID dropped or ARADDR changed before ARREADY");
        end

    resetState: assert property (@(posedge clk)
            reset |=> !bvalid && !rvalid && awready && wready && arready)
        else begin
            failCount++;
            $error("response valid high or channel not ready after reset");
        end

endmodule

bind memSubsystem memSubsystemSva i_sva (.*);

// File: test/memSubsystemTb.sv
`timescale 1ns/100ps
`include "mem_params.svh"

module memSubsystemTb
    import memPkg::*;
();

    localparam int ClkHalf        = 4;               // 8 ns period
    localparam int ResetCycles    = 4;
    localparam int MaxRandStall   = 6;               // longest random READY stall
    localparam int CyclesPerEntry = 48;              // worst case for one table entry
    localparam int WordIdxW       = `MEM_BANK_W + `MEM_ROW_W;
    localparam logic [1:0] OpWrite  = 2'd0;
    localparam logic [1:0] OpRead   = 2'd1;
    localparam logic [1:0] OpWrRd   = 2'd2;          // write and read launched together
    localparam logic [7:0] StallRnd = 8'hFF;         // stall length drawn from $random

    typedef struct packed {
        logic [1:0]             op;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;    // write data, unused by reads
        logic [`MEM_STRB_W-1:0] strb;
        logic [7:0]             bStall;  // cycles BREADY stays low once BVALID is up
        logic [7:0]             rStall;  // same for RREADY
        axiResp_t               resp;    // expected response code
    } testEntry_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   awvalid;
    logic                   awready;
    logic [`MEM_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_STRB_W-1:0] wstrb;
    logic                   bvalid;
    logic                   bready;
    axiResp_t               bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`MEM_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [`MEM_DATA_W-1:0] rdata;
    axiResp_t               rresp;

    testEntry_t             stim [$];                // stimulus table
    logic [`MEM_DATA_W-1:0] refMem [`MEM_WORDS];     // reference copy of the memory
    int                     seed = 32'h2f616e77;
    bit                     tableLoaded = 1'b0;
    int                     mismatches = 0;
    int                     otherErrors = 0;

    always #ClkHalf clk = ~clk;

    memSubsystem i_dut (.*);

    task automatic reportMismatch(input string msg);
        mismatches++;
        $display("Mismatch at %t: %s", $time, msg);
    endtask

    task automatic reportError(input string msg);
        otherErrors++;
        $display("Error at %t: %s", $time, msg);
    endtask

    task automatic addEntry(input logic [1:0] op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [7:0] bStall,
                            input logic [7:0] rStall, input axiResp_t resp);
        stim.push_back('{op: op, addr: addr, data: data, strb: strb,
                         bStall: bStall, rStall: rStall, resp: resp});
    endtask

    task automatic buildTable();
        // op       addr           data           strb   bStall    rStall    resp
        addEntry(OpWrite, 32'h0000_0000, 32'h1111_0000, 4'hF, 8'd0,     8'd0,     OKAY); // bank 0
        addEntry(OpWrite, 32'h0000_0004, 32'h2222_0001, 4'hF, 8'd1,     8'd0,     OKAY); // bank 1
        addEntry(OpWrite, 32'h0000_0008, 32'h3333_0002, 4'hF, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_000C, 32'h4444_0003, 4'hF, 8'd2,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_07FC, 32'hCAFE_01FF, 4'hF, 8'd0,     8'd0,     OKAY); // last word
        addEntry(OpWrite, 32'h0000_0400, 32'h0BAD_0100, 4'hF, 8'd0,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0000, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0004, 32'h0,         4'h0, 8'd0,     8'd1,     OKAY);
        addEntry(OpRead,  32'h0000_0008, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_000C, 32'h0,         4'h0, 8'd0,     8'd3,     OKAY);
        addEntry(OpRead,  32'h0000_07FC, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0400, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_0010, 32'hA5A5_5A5A, 4'h5, 8'd0,     8'd0,     OKAY); // lanes 0,2
        addEntry(OpWrite, 32'h0000_0010, 32'h7700_0000, 4'h8, 8'd1,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0010, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_0800, 32'hFFFF_FFFF, 4'hF, 8'd0,     8'd0,     SLVERR); // aliases 0
        addEntry(OpRead,  32'h0000_0000, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrite, 32'h0000_0804, 32'hFFFF_FFFF, 4'hF, 8'd2,     8'd0,     SLVERR);
        addEntry(OpRead,  32'h0000_0004, 32'h0,         4'h0, 8'd0,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_FFFC, 32'h0,         4'h0, 8'd0,     8'd2,     SLVERR);
        addEntry(OpRead,  32'h0000_0800, 32'h0,         4'h0, 8'd0,     8'd0,     SLVERR);
        addEntry(OpWrite, 32'h0000_0014, 32'h5555_0005, 4'hF, StallRnd, 8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0014, 32'h0,         4'h0, 8'd0,     StallRnd, OKAY);
        addEntry(OpWrite, 32'h0000_0018, 32'h6666_0006, 4'hF, 8'd7,     8'd0,     OKAY);
        addEntry(OpRead,  32'h0000_0018, 32'h0,         4'h0, 8'd0,     8'd7,     OKAY);
        addEntry(OpRead,  32'h0000_0008, 32'h0,         4'h0, 8'd0,     StallRnd, OKAY);
        addEntry(OpWrRd,  32'h0000_0020, 32'h1234_5678, 4'hF, 8'd0,     8'd0,     OKAY);
        addEntry(OpWrRd,  32'h0000_0010, 32'h0000_1200, 4'h2, 8'd3,     StallRnd, OKAY);
        addEntry(OpWrRd,  32'h0000_07FC, 32'h8765_4321, 4'hF, StallRnd, 8'd2,     OKAY);
        addEntry(OpWrRd,  32'h0000_0C00, 32'hFFFF_FFFF, 4'hF, 8'd1,     8'd1,     SLVERR);
    endtask

    function automatic int pickStall(input logic [7:0] count);
        if (count == StallRnd) return $unsigned($random(seed)) % (MaxRandStall + 1);
        return int'(count);
    endfunction

    // byte lanes with a strobe bit take the new data, nothing lands outside the window
    function automatic void applyWrite(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
        if (addr >= 32'(`MEM_WINDOW)) return;
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            if (strb[b]) refMem[addr[2 +: WordIdxW]][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    function automatic logic [31:0] expectedData(input logic [31:0] addr);
        if (addr >= 32'(`MEM_WINDOW)) return '0;  // out of window reads as zero
        return refMem[addr[2 +: WordIdxW]];
    endfunction

    task automatic writeTransfer(input testEntry_t e, input int stall);
        bit       awDone;
        bit       wDone;
        bit       awNow;
        bit       wNow;
        int       edges;
        axiResp_t firstResp;
        awDone = 1'b0;
        wDone  = 1'b0;
        edges  = 0;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= e.addr;
        wvalid  <= 1'b1;
        wdata   <= e.data;
        wstrb   <= e.strb;
        bready  <= (stall == 0);           // no stall means ready before BVALID
        while (!(awDone && wDone)) begin
            @(negedge clk);
            awNow = awvalid && awready;      // handshake happens on the next edge
            wNow  = wvalid && wready;
            @(posedge clk);
            if (awNow) begin
                awvalid <= 1'b0;
                awDone = 1'b1;
            end
            if (wNow) begin
                wvalid <= 1'b0;
                wDone = 1'b1;
            end
        end
        @(negedge clk);
        while (!bvalid) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        assert (edges == 2)
            else reportMismatch($sformatf("write 0x%08h BVALID after %0d cycles, expected 2",
                                          e.addr, edges));
        assert (bresp == e.resp)
            else reportMismatch($sformatf("write 0x%08h BRESP %0h, expected %0h",
                                          e.addr, bresp, e.resp));
        firstResp = bresp;
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            assert (bvalid && bresp == firstResp)
                else reportError($sformatf("B response for 0x%08h lost or changed while stalled",
                                           e.addr));
        end
        if (stall != 0) begin
            @(posedge clk);
            bready <= 1'b1;
            @(negedge clk);
            assert (bvalid) else reportError("BVALID dropped before BREADY rose");
        end
        @(posedge clk);                      // B handshake
        bready <= 1'b0;
        @(negedge clk);
        assert (!bvalid) else reportError("a second B response followed the handshake");
    endtask

    task automatic readTransfer(input testEntry_t e, input int stall, input int expLatency);
        logic [`MEM_DATA_W-1:0] expData;
        logic [`MEM_DATA_W-1:0] firstData;
        axiResp_t               firstResp;
        bit                     arNow;
        int                     edges;
        expData = expectedData(e.addr);
        edges   = 0;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= e.addr;
        rready  <= (stall == 0);
        do begin
            @(negedge clk);
            arNow = arready;
            @(posedge clk);
        end while (!arNow);
        arvalid <= 1'b0;                     // AR accepted on this edge
        @(negedge clk);
        while (!rvalid) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        assert (edges == expLatency)
            else reportMismatch($sformatf("read 0x%08h RVALID after %0d cycles, expected %0d",
                                          e.addr, edges, expLatency));
        assert (rdata === expData && rresp == e.resp)
            else reportMismatch($sformatf("read 0x%08h gave 0x%08h/%0h, expected 0x%08h/%0h",
                                          e.addr, rdata, rresp, expData, e.resp));
        firstData = rdata;
        firstResp = rresp;
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            assert (rvalid && rdata === firstData && rresp == firstResp)
                else reportError($sformatf("R response for 0x%08h lost or changed while stalled",
                                           e.addr));
        end
        if (stall != 0) begin
            @(posedge clk);
            rready <= 1'b1;
            @(negedge clk);
            assert (rvalid) else reportError("RVALID dropped before RREADY rose");
        end
        @(posedge clk);                      // R handshake
        rready <= 1'b0;
        @(negedge clk);
        assert (!rvalid) else reportError("a second R response followed the handshake");
    endtask

    task automatic printCounts();
        $display("Summary: %0d entries, %0d mismatches, %0d other errors, %0d SVA failures",
                 stim.size(), mismatches, otherErrors, i_dut.i_sva.failCount);
    endtask

    initial begin : mainFlow
        testEntry_t e;
        int         bStall;
        int         rStall;
        $timeformat(-9, 1, " ns", 0);
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        buildTable();
        tableLoaded = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!bvalid && !rvalid) else reportMismatch("BVALID or RVALID high after reset");
        assert (awready && wready && arready) else reportMismatch("AW, W or AR not ready after reset");
        foreach (stim[i]) begin
            e      = stim[i];
            bStall = pickStall(e.bStall);
            rStall = pickStall(e.rStall);
            case (e.op)
                OpWrite: begin
                    applyWrite(e.addr, e.data, e.strb);
                    writeTransfer(e, bStall);
                end
                OpRead: readTransfer(e, rStall, 2);
                default: begin
                    applyWrite(e.addr, e.data, e.strb);  // write is served first
                    fork
                        writeTransfer(e, bStall);
                        readTransfer(e, rStall, 3);     // read issue slips one cycle
                    join
                end
            endcase
        end
        repeat (2) @(posedge clk);
        printCounts();
        if (mismatches == 0 && otherErrors == 0 && i_dut.i_sva.failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        longint limitNs;
        wait (tableLoaded);
        limitNs = longint'(ResetCycles + 8 + stim.size() * CyclesPerEntry) * 2 * ClkHalf;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        printCounts();
        $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/memPkg.sv
verilog/memBank.sv
verilog/axiLiteFrontEnd.sv
verilog/readMerge.sv
verilog/memSubsystem.sv
test/memSubsystem_sva.sv
test/memSubsystemTb.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Test completed successfully
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
